// ==== hdl/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

//Width of the data path and of every bus address
`define XLEN 32

//Address of the first instruction fetched after reset
`define RESET_VECTOR 32'h00000000

//x0 through x31
`define REGISTER_COUNT 32

`endif

// ==== hdl/CoreTypes.sv ====
`include "core_config.svh"

package CoreTypes;

//What the bus does this cycle
typedef enum logic [1:0]
{
	NOP,
	FETCH,
	LOAD,
	STORE
} MemoryMode_t;

//Write-back source for rd
typedef enum logic [1:0]
{
	MEMORY,
	ALU,
	IMMEDIATE,
	LINK//pc + 4 from jal/jalr
} RdSource_t;

typedef enum logic [2:0]
{
	I_TYPE,
	S_TYPE,
	B_TYPE,
	U_TYPE,
	J_TYPE,
	LUI,
	AUIPC//U immediate already added to pc
} ImmediateFormerMode_t;

//Next pc selection
typedef enum logic [1:0]
{
	INCREMENT,
	BRANCH,
	JAL,
	JALR
} BranchALUMode_t;

typedef enum logic [2:0]
{
	RUNNING,
	STOP,//ecall/ebreak
	CONTROL_ERROR,//Unknown opcode
	BAD_FUNCT3,
	MISALIGNED//Data access or jump target
} HaltCause_t;

//Everything ControlLogic tells the datapath
typedef struct packed
{
	logic rdWriteEnable;
	MemoryMode_t memoryMode;
	RdSource_t rdSource;
	logic programCounterWriteEnable;
	logic opImm;
	ImmediateFormerMode_t immediateFormerMode;
	BranchALUMode_t branchALUMode;
} ControlLines_t;

//Master to slave
typedef struct packed
{
	logic cyc;
	logic stb;
	logic we;
	logic [3:0] sel;
	logic [`XLEN-1:0] adr;
	logic [`XLEN-1:0] dat;
} WishboneRequest_t;

//Slave to master
typedef struct packed
{
	logic ack;
	logic [`XLEN-1:0] dat;
} WishboneResponse_t;

endpackage

// ==== hdl/ControlLogic.sv ====
`timescale 1ns/1ps

module ControlLogic
(
	input logic clock, reset,

	input logic [31:0] instruction,//From the fetch latch

	//Bus handshake and error flags
	input logic busDone,
	input logic memoryMisaligned,
	input logic memoryBadFunct3,
	input logic badBranchFunct3,
	input logic targetMisaligned,

	output CoreTypes::ControlLines_t controlLines,
	output logic halted,
	output CoreTypes::HaltCause_t haltCause
);

typedef enum logic [3:0]
{//One-hot
	FETCH = 4'b0001,
	EXECUTE = 4'b0010,
	MEMORY = 4'b0100,
	HALT = 4'b1000
} State_t;
State_t currentState, nextState;

CoreTypes::ControlLines_t decodedLines;//Per-opcode lines before state gating
CoreTypes::HaltCause_t nextCause;
logic [6:0] opcode;
logic isMemoryAccess;//Load or store that needs the MEMORY state
logic controlError;
logic stop;
logic haltNow;

assign opcode = instruction[6:0];
assign isMemoryAccess = decodedLines.memoryMode != CoreTypes::NOP;

always_ff @(posedge clock)
begin
	if (reset)
	begin
		currentState <= FETCH;
		haltCause <= CoreTypes::RUNNING;
	end
	else
	begin
		currentState <= nextState;
		if (haltNow)
			haltCause <= nextCause;//Only once since HALT never exits
	end
end

always_comb
begin
	case (currentState)
		FETCH: nextState = busDone ? EXECUTE : FETCH;//Wait for the instruction
		EXECUTE:
		begin
			if (haltNow)
				nextState = HALT;
			else if (isMemoryAccess)
				nextState = MEMORY;
			else
				nextState = FETCH;
		end
		MEMORY: nextState = busDone ? FETCH : MEMORY;
		default: nextState = HALT;//HALT and corrupt encodings
	endcase
end

//Opcode decode
always_comb
begin
	decodedLines.rdWriteEnable = 1'b0;
	decodedLines.memoryMode = CoreTypes::NOP;
	decodedLines.rdSource = CoreTypes::ALU;
	decodedLines.programCounterWriteEnable = 1'b1;//Gated by state below
	decodedLines.opImm = 1'b0;
	decodedLines.immediateFormerMode = CoreTypes::I_TYPE;
	decodedLines.branchALUMode = CoreTypes::INCREMENT;
	controlError = 1'b0;
	stop = 1'b0;

	case (opcode)
		7'b0110111://lui
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.rdSource = CoreTypes::IMMEDIATE;
			decodedLines.immediateFormerMode = CoreTypes::LUI;
		end
		7'b0010111://auipc
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.rdSource = CoreTypes::IMMEDIATE;
			decodedLines.immediateFormerMode = CoreTypes::AUIPC;
		end
		7'b1101111://jal
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.rdSource = CoreTypes::LINK;
			decodedLines.immediateFormerMode = CoreTypes::J_TYPE;
			decodedLines.branchALUMode = CoreTypes::JAL;
		end
		7'b1100111://jalr
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.rdSource = CoreTypes::LINK;
			decodedLines.branchALUMode = CoreTypes::JALR;//I immediate plus rs1
		end
		7'b1100011://Branches
		begin
			decodedLines.immediateFormerMode = CoreTypes::B_TYPE;
			decodedLines.branchALUMode = CoreTypes::BRANCH;
		end
		7'b0000011://Loads
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.memoryMode = CoreTypes::LOAD;
			decodedLines.rdSource = CoreTypes::MEMORY;
		end
		7'b0100011://Stores
		begin
			decodedLines.memoryMode = CoreTypes::STORE;
			decodedLines.immediateFormerMode = CoreTypes::S_TYPE;
		end
		7'b0010011://OP-IMM
		begin
			decodedLines.rdWriteEnable = 1'b1;
			decodedLines.opImm = 1'b1;
		end
		7'b0110011: decodedLines.rdWriteEnable = 1'b1;//OP
		7'b0001111: ;//fence does nothing here
		7'b1110011: stop = 1'b1;//ecall/ebreak stop cleanly
		default: controlError = 1'b1;
	endcase
end

//Halt cause priority
always_comb
begin
	if (controlError)
		nextCause = CoreTypes::CONTROL_ERROR;
	else if (stop)
		nextCause = CoreTypes::STOP;
	else if (badBranchFunct3 || (isMemoryAccess && memoryBadFunct3))
		nextCause = CoreTypes::BAD_FUNCT3;
	else if (targetMisaligned || (isMemoryAccess && memoryMisaligned))
		nextCause = CoreTypes::MISALIGNED;
	else
		nextCause = CoreTypes::RUNNING;
end

assign haltNow = (currentState == EXECUTE) && (nextCause != CoreTypes::RUNNING);

//State gating of the decoded lines
always_comb
begin
	controlLines = decodedLines;
	case (currentState)
		FETCH:
		begin
			controlLines.memoryMode = CoreTypes::FETCH;
			controlLines.rdWriteEnable = 1'b0;
			controlLines.programCounterWriteEnable = 1'b0;
		end
		EXECUTE:
		begin
			controlLines.memoryMode = CoreTypes::NOP;//Data access starts in MEMORY
			if (haltNow || isMemoryAccess)
			begin
				controlLines.rdWriteEnable = 1'b0;
				controlLines.programCounterWriteEnable = 1'b0;
			end
		end
		MEMORY:
		begin
			controlLines.rdWriteEnable = decodedLines.rdWriteEnable && busDone;//Loads only
			controlLines.programCounterWriteEnable = busDone;
		end
		default:
		begin
			controlLines.memoryMode = CoreTypes::NOP;//No bus traffic once halted
			controlLines.rdWriteEnable = 1'b0;
			controlLines.programCounterWriteEnable = 1'b0;
		end
	endcase
end

assign halted = currentState == HALT;

endmodule

// ==== hdl/RegisterFile.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module RegisterFile
(
	input logic clock, reset,
	input CoreTypes::ControlLines_t controlLines,
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] aluResult, immediate, linkValue, loadData,//Write-back candidates
	output logic [`XLEN-1:0] rs1Value, rs2Value
);

logic [`XLEN-1:0] registers [1:`REGISTER_COUNT-1];//No storage for x0
logic [`XLEN-1:0] rdValue;
logic [4:0] rs1, rs2, rd;

assign rs1 = instruction[19:15];
assign rs2 = instruction[24:20];
assign rd = instruction[11:7];

always_comb
begin
	case (controlLines.rdSource)
		CoreTypes::MEMORY: rdValue = loadData;
		CoreTypes::ALU: rdValue = aluResult;
		CoreTypes::IMMEDIATE: rdValue = immediate;//lui/auipc
		default: rdValue = linkValue;
	endcase
end

always_ff @(posedge clock)
begin
	if (reset)
	begin
		for (int i = 1; i < `REGISTER_COUNT; i++)
			registers[i] <= '0;
	end
	else if (controlLines.rdWriteEnable && (rd != 5'd0))//Writes to x0 dropped
		registers[rd] <= rdValue;
end

assign rs1Value = (rs1 == 5'd0) ? '0 : registers[rs1];
assign rs2Value = (rs2 == 5'd0) ? '0 : registers[rs2];

endmodule

// ==== hdl/ALU.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module ALU
(
	input logic [31:0] instruction,
	input logic opImm,//Immediate replaces rs2
	input logic [`XLEN-1:0] rs1Value, rs2Value, immediate,
	output logic [`XLEN-1:0] aluResult
);

logic [`XLEN-1:0] operandB;
logic [2:0] funct3;
logic funct7Bit5;//sub and sra/srai
logic [4:0] shiftAmount;
logic signedLess, unsignedLess;

assign funct3 = instruction[14:12];
assign funct7Bit5 = instruction[30];
assign operandB = opImm ? immediate : rs2Value;
assign shiftAmount = operandB[4:0];//Also the shamt field for OP-IMM
assign signedLess = $signed(rs1Value) < $signed(operandB);
assign unsignedLess = rs1Value < operandB;

always_comb
begin
	case (funct3)
		3'b000://add/addi/sub
		begin
			if (funct7Bit5 && !opImm)
				aluResult = rs1Value - operandB;
			else
				aluResult = rs1Value + operandB;
		end
		3'b001: aluResult = rs1Value << shiftAmount;
		3'b010: aluResult = {{(`XLEN-1){1'b0}}, signedLess};
		3'b011: aluResult = {{(`XLEN-1){1'b0}}, unsignedLess};
		3'b100: aluResult = rs1Value ^ operandB;
		3'b101://srl/sra and the immediate forms
		begin
			if (funct7Bit5)
				aluResult = $signed(rs1Value) >>> shiftAmount;
			else
				aluResult = rs1Value >> shiftAmount;
		end
		3'b110: aluResult = rs1Value | operandB;
		default: aluResult = rs1Value & operandB;
	endcase
end

endmodule

// ==== hdl/ImmediateFormer.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module ImmediateFormer
(
	input logic [31:0] instruction,
	input CoreTypes::ImmediateFormerMode_t immediateFormerMode,
	input logic [`XLEN-1:0] pc,//Base for auipc
	output logic [`XLEN-1:0] immediate
);

logic [`XLEN-1:0] uImmediate;

assign uImmediate = {instruction[31:12], 12'h000};

always_comb
begin
	case (immediateFormerMode)
		CoreTypes::I_TYPE: immediate = {{20{instruction[31]}}, instruction[31:20]};
		CoreTypes::S_TYPE: immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
		CoreTypes::B_TYPE:
			immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
				instruction[30:25], instruction[11:8], 1'b0};
		CoreTypes::J_TYPE:
			immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
				instruction[20], instruction[30:21], 1'b0};
		CoreTypes::U_TYPE, CoreTypes::LUI: immediate = uImmediate;
		CoreTypes::AUIPC: immediate = uImmediate + pc;//Finished auipc result
		default: immediate = '0;
	endcase
end

endmodule

// ==== hdl/ProgramCounter.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module ProgramCounter
(
	input logic clock, reset,
	input CoreTypes::ControlLines_t controlLines,
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] rs1Value, rs2Value, immediate,
	output logic [`XLEN-1:0] pc, linkValue,
	output logic badBranchFunct3, targetMisaligned
);

logic [`XLEN-1:0] nextPc;
logic [`XLEN-1:0] relativeTarget;//pc + B or J immediate
logic [`XLEN-1:0] jalrSum;
logic [2:0] funct3;
logic branchTaken;

assign funct3 = instruction[14:12];
assign linkValue = pc + 4;
assign relativeTarget = pc + immediate;
assign jalrSum = rs1Value + immediate;

//Branch comparison
always_comb
begin
	case (funct3)
		3'b000: branchTaken = rs1Value == rs2Value;//beq
		3'b001: branchTaken = rs1Value != rs2Value;//bne
		3'b100: branchTaken = $signed(rs1Value) < $signed(rs2Value);//blt
		3'b101: branchTaken = $signed(rs1Value) >= $signed(rs2Value);//bge
		3'b110: branchTaken = rs1Value < rs2Value;//bltu
		3'b111: branchTaken = rs1Value >= rs2Value;//bgeu
		default: branchTaken = 1'b0;
	endcase
end

always_comb
begin
	case (controlLines.branchALUMode)
		CoreTypes::INCREMENT: nextPc = linkValue;
		CoreTypes::BRANCH: nextPc = branchTaken ? relativeTarget : linkValue;
		CoreTypes::JAL: nextPc = relativeTarget;
		default: nextPc = {jalrSum[`XLEN-1:1], 1'b0};//jalr clears bit 0
	endcase
end

assign badBranchFunct3 = (controlLines.branchALUMode == CoreTypes::BRANCH) &&
	(funct3[2:1] == 2'b01);//funct3 2 and 3
assign targetMisaligned = nextPc[1];//Untaken branches never trip this

always_ff @(posedge clock)
begin
	if (reset)
		pc <= `RESET_VECTOR;
	else if (controlLines.programCounterWriteEnable)
		pc <= nextPc;
end

endmodule

// ==== hdl/MemoryController.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module MemoryController
(
	input logic clock, reset,
	input CoreTypes::ControlLines_t controlLines,
	input logic [31:0] instruction,
	input logic [`XLEN-1:0] pc, rs1Value, rs2Value, immediate,
	output CoreTypes::WishboneRequest_t request,
	input CoreTypes::WishboneResponse_t response,
	output logic busDone,//Ack of the current transfer
	output logic [31:0] latchedInstruction,
	output logic [`XLEN-1:0] loadData,
	output logic misaligned, badFunct3
);

logic [`XLEN-1:0] dataAddress;
logic [1:0] offset;//Byte within the word
logic [2:0] funct3;
logic isStore;
logic [3:0] laneSelect;
logic [`XLEN-1:0] storeData;
logic [`XLEN-1:0] shiftedData;
logic busActive;//Drives both cyc and stb
logic busWrite;
logic [3:0] busSelect;
logic [`XLEN-1:0] busAddress, busData;

assign dataAddress = rs1Value + immediate;
assign offset = dataAddress[1:0];
assign funct3 = instruction[14:12];
assign isStore = instruction[5];//Store and load opcodes differ only here

//Checked in EXECUTE before any data cycle
assign misaligned = ((funct3[1:0] == 2'b01) && offset[0]) ||
	((funct3[1:0] == 2'b10) && (offset != 2'b00));
assign badFunct3 = (funct3[1:0] == 2'b11) || (funct3[2] && (isStore || funct3[1]));

//Byte lanes and replicated store data
always_comb
begin
	case (funct3[1:0])
		2'b00:
		begin
			laneSelect = 4'b0001 << offset;
			storeData = {4{rs2Value[7:0]}};
		end
		2'b01:
		begin
			laneSelect = 4'b0011 << offset;
			storeData = {2{rs2Value[15:0]}};
		end
		default:
		begin
			laneSelect = 4'b1111;
			storeData = rs2Value;
		end
	endcase
end

always_ff @(posedge clock)
begin
	if (reset)
		busActive <= 1'b0;
	else if (busActive)
		busActive <= ~response.ack;//Drop on the ack edge
	else
		busActive <= controlLines.memoryMode != CoreTypes::NOP;
end

//Request payload follows the datapath while idle and freezes during a transfer
always_ff @(posedge clock)
begin
	if (!busActive)
	begin
		busWrite <= controlLines.memoryMode == CoreTypes::STORE;
		busAddress <= (controlLines.memoryMode == CoreTypes::FETCH) ? pc :
			{dataAddress[`XLEN-1:2], 2'b00};
		busSelect <= (controlLines.memoryMode == CoreTypes::FETCH) ? 4'b1111 : laneSelect;
		busData <= storeData;
	end
end

assign request.cyc = busActive;
assign request.stb = busActive;
assign request.we = busWrite;
assign request.sel = busSelect;
assign request.adr = busAddress;
assign request.dat = busData;
assign busDone = busActive && response.ack;

always_ff @(posedge clock)
begin
	if (reset)
		latchedInstruction <= 32'h00000013;//addi x0, x0, 0
	else if (busDone && (controlLines.memoryMode == CoreTypes::FETCH))
		latchedInstruction <= response.dat;
end

//Load alignment and extension for the rd write on the ack edge
assign shiftedData = response.dat >> {offset, 3'b000};

always_comb
begin
	case (funct3)
		3'b000: loadData = {{24{shiftedData[7]}}, shiftedData[7:0]};//lb
		3'b001: loadData = {{16{shiftedData[15]}}, shiftedData[15:0]};//lh
		3'b100: loadData = {24'h000000, shiftedData[7:0]};//lbu
		3'b101: loadData = {16'h0000, shiftedData[15:0]};//lhu
		default: loadData = shiftedData;
	endcase
end

endmodule

// ==== hdl/Core.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module Core
(
	input logic clock, reset,
	output CoreTypes::WishboneRequest_t request,
	input CoreTypes::WishboneResponse_t response,
	output logic halted,
	output CoreTypes::HaltCause_t haltCause
);

CoreTypes::ControlLines_t controlLines;
logic [31:0] instruction;//Latched by MemoryController
logic [`XLEN-1:0] pc, rs1Value, rs2Value;
logic [`XLEN-1:0] aluResult, immediate, linkValue, loadData;
logic busDone;
logic memoryMisaligned, memoryBadFunct3;
logic badBranchFunct3, targetMisaligned;

ControlLogic controlLogic
(
	.clock(clock), .reset(reset), .instruction(instruction), .busDone(busDone),
	.memoryMisaligned(memoryMisaligned), .memoryBadFunct3(memoryBadFunct3),
	.badBranchFunct3(badBranchFunct3), .targetMisaligned(targetMisaligned),
	.controlLines(controlLines), .halted(halted), .haltCause(haltCause)
);

RegisterFile registerFile
(
	.clock(clock), .reset(reset), .controlLines(controlLines), .instruction(instruction),
	.aluResult(aluResult), .immediate(immediate), .linkValue(linkValue),
	.loadData(loadData), .rs1Value(rs1Value), .rs2Value(rs2Value)
);

ALU alu
(
	.instruction(instruction), .opImm(controlLines.opImm), .rs1Value(rs1Value),
	.rs2Value(rs2Value), .immediate(immediate), .aluResult(aluResult)
);

ImmediateFormer immediateFormer
(
	.instruction(instruction), .immediateFormerMode(controlLines.immediateFormerMode),
	.pc(pc), .immediate(immediate)
);

ProgramCounter programCounter
(
	.clock(clock), .reset(reset), .controlLines(controlLines), .instruction(instruction),
	.rs1Value(rs1Value), .rs2Value(rs2Value), .immediate(immediate), .pc(pc),
	.linkValue(linkValue), .badBranchFunct3(badBranchFunct3),
	.targetMisaligned(targetMisaligned)
);

MemoryController memoryController
(
	.clock(clock), .reset(reset), .controlLines(controlLines), .instruction(instruction),
	.pc(pc), .rs1Value(rs1Value), .rs2Value(rs2Value), .immediate(immediate),
	.request(request), .response(response), .busDone(busDone),
	.latchedInstruction(instruction), .loadData(loadData),
	.misaligned(memoryMisaligned), .badFunct3(memoryBadFunct3)
);

endmodule

// ==== test/CoreChk.sv ====
`timescale 1ns/1ps

module CoreChk
(
	input logic clock, reset,
	input CoreTypes::WishboneRequest_t request,
	input CoreTypes::WishboneResponse_t response,
	input logic halted
);

//Strobe only inside a cycle
assertStbInCyc: assert property (@(posedge clock) disable iff (reset)
	request.stb |-> request.cyc)
	else $error("stb high without cyc");

//Payload frozen until the slave acks
assertStable: assert property (@(posedge clock) disable iff (reset)
	(request.stb && !response.ack) |=>
	(request.stb && $stable({request.we, request.sel, request.adr, request.dat})))
	else $error("Wishbone request changed before ack");

assertIdleHalted: assert property (@(posedge clock) disable iff (reset)
	halted |-> !request.cyc)
	else $error("Bus cycle while halted");

//Halt is sticky
assertHaltSticky: assert property (@(posedge clock) disable iff (reset)
	halted |=> halted)
	else $error("halted fell without reset");

endmodule

// ==== test/CoreTb.sv ====
`timescale 1ns/1ps

module CoreTb;

localparam int ROWS = 10;
localparam int WORDS = 12;//Program words per row
localparam int MAX_STORES = 6;
localparam logic [31:0] ECALL = 32'h00000073;
localparam logic [31:0] LOAD_WORD = 32'h82f17e91;//Bytes 91 7e f1 82 at 0x100

logic clock = 1'b0;
logic reset = 1'b1;
CoreTypes::WishboneRequest_t request;
CoreTypes::WishboneResponse_t response = '0;
logic halted;
CoreTypes::HaltCause_t haltCause;

//Program table
logic [31:0] programs [ROWS][WORDS];
int codeLengths [ROWS];
CoreTypes::WishboneRequest_t stores [ROWS][MAX_STORES];
int storeCounts [ROWS];
CoreTypes::HaltCause_t causes [ROWS];
int loadCounts [ROWS];
int row = 0;

logic [31:0] memory [128];
CoreTypes::WishboneRequest_t expectedStores [$];
logic [31:0] lfsr = 32'hcac8;
logic busy = 1'b0;
int waitLeft = 0;
int loadReads = 0;//Data reads seen by the memory

Core i_dut (.clock(clock), .reset(reset), .request(request), .response(response),
	.halted(halted), .haltCause(haltCause));

bind Core CoreChk coreChk (.clock(clock), .reset(reset), .request(request),
	.response(response), .halted(halted));

always #20 clock = ~clock;

task automatic stopOnError(input string line);
	$display("%s", line);
	$display("SOME TESTS FAILED");
	$fatal(1);
endtask

//x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] stepLfsr(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

task automatic drawWait(output int cycles);
	cycles = 0;
	for (int i = 0; i < 2; i++)
	begin
		lfsr = stepLfsr(lfsr);
		cycles = (cycles << 1) | int'(lfsr[0]);
	end
endtask

//Instruction encoders
function automatic logic [31:0] encI(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
	logic [4:0] rd, logic [6:0] op);
	return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] encS(logic [31:0] imm, logic [4:0] rs2, logic [2:0] f3);
	return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};//Base always x0
endfunction

function automatic logic [31:0] encB(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] encJ(logic [31:0] imm, logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
	logic [2:0] f3, logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

task automatic addWord(input logic [31:0] word);
	programs[row][codeLengths[row]] = word;
	codeLengths[row]++;
endtask

task automatic addStore(input logic [31:0] adr, input logic [3:0] sel, input logic [31:0] dat);
	CoreTypes::WishboneRequest_t s;
	s = '0;
	s.cyc = 1'b1;
	s.stb = 1'b1;
	s.we = 1'b1;
	s.sel = sel;
	s.adr = adr;
	s.dat = dat;
	stores[row][storeCounts[row]] = s;
	storeCounts[row]++;
endtask

task automatic endRow(input CoreTypes::HaltCause_t cause, input int loads);
	causes[row] = cause;
	loadCounts[row] = loads;
	row++;
endtask

task automatic checkStore(input CoreTypes::WishboneRequest_t actual,
	input CoreTypes::WishboneRequest_t expected);
	if (actual !== expected)
		stopOnError($sformatf("Error at %0t ns: store adr %h sel %b dat %h, expected %h %b %h",
			$time, actual.adr, actual.sel, actual.dat, expected.adr, expected.sel, expected.dat));
endtask

task automatic checkHalt(input CoreTypes::HaltCause_t actual,
	input CoreTypes::HaltCause_t expected);
	if (actual !== expected)
		stopOnError($sformatf("Error at %0t ns: halt cause %s, expected %s",
			$time, actual.name(), expected.name()));
endtask

task automatic checkLoadCount(input int actual, input int expected);
	if (actual != expected)
		stopOnError($sformatf("Error at %0t ns: %0d data reads, expected %0d",
			$time, actual, expected));
endtask

//Wishbone slave with random wait states
always
begin
	@(posedge clock);
	#1;
	if (reset || response.ack)
	begin
		response.ack = 1'b0;
		busy = 1'b0;
	end
	else if (request.stb)
	begin
		if (!busy)
		begin
			busy = 1'b1;
			drawWait(waitLeft);
		end
		if (waitLeft == 0)
		begin
			if (request.we)
			begin
				if (expectedStores.size() == 0)
					stopOnError($sformatf("Unexpected store to address %h", request.adr));
				else
					checkStore(request, expectedStores.pop_front());
				for (int b = 0; b < 4; b++)
					if (request.sel[b])
						memory[request.adr[8:2]][b*8 +: 8] = request.dat[b*8 +: 8];
			end
			else
			begin
				response.dat = memory[request.adr[8:2]];
				if (request.adr >= 32'h100)
					loadReads++;//Code lives below 0x100
			end
			response.ack = 1'b1;
		end
		else
			waitLeft--;
	end
end

//Watchdog
initial
begin
	#(ROWS * WORDS * 12 * 40 + 20000);
	stopOnError("Timeout: the core did not halt in time");
end

initial
begin
	for (int r = 0; r < ROWS; r++)
	begin
		codeLengths[r] = 0;
		storeCounts[r] = 0;
	end

	//ALU and immediates
	addWord(encI(-5, 0, 3'd0, 1, 7'h13));
	addWord({20'h12345, 5'd2, 7'h37});
	addWord({20'h00001, 5'd3, 7'h17});//auipc at pc 8
	addWord(encS(32'h100, 1, 3'd2));
	addWord(encS(32'h104, 2, 3'd2));
	addWord(encS(32'h108, 3, 3'd2));
	addWord(encR(7'h00, 2, 1, 3'd0, 4));
	addWord(encS(32'h10c, 4, 3'd2));
	addWord(encR(7'h20, 1, 2, 3'd0, 5));//x2 - x1
	addWord(encS(32'h110, 5, 3'd2));
	addWord(ECALL);
	addStore(32'h100, 4'hf, 32'hfffffffb);
	addStore(32'h104, 4'hf, 32'h12345000);
	addStore(32'h108, 4'hf, 32'h00001008);
	addStore(32'h10c, 4'hf, 32'h12344ffb);
	addStore(32'h110, 4'hf, 32'h12345005);
	endRow(CoreTypes::STOP, 0);

	addWord(encI(-5, 0, 3'd0, 1, 7'h13));
	addWord(encI(7, 0, 3'd0, 2, 7'h13));
	addWord(encR(7'h00, 2, 1, 3'd4, 3));//xor
	addWord(encS(32'h100, 3, 3'd2));
	addWord(encR(7'h00, 2, 1, 3'd2, 4));//slt
	addWord(encS(32'h104, 4, 3'd2));
	addWord(encR(7'h00, 2, 1, 3'd3, 5));//sltu
	addWord(encS(32'h108, 5, 3'd2));
	addWord(encI(32'h401, 1, 3'd5, 6, 7'h13));//srai by 1
	addWord(encS(32'h10c, 6, 3'd2));
	addWord(ECALL);
	addStore(32'h100, 4'hf, 32'hfffffffc);
	addStore(32'h104, 4'hf, 32'h00000001);
	addStore(32'h108, 4'hf, 32'h00000000);
	addStore(32'h10c, 4'hf, 32'hfffffffd);
	endRow(CoreTypes::STOP, 0);

	addWord(encI(-5, 0, 3'd0, 1, 7'h13));
	addWord(encI(7, 0, 3'd0, 2, 7'h13));
	addWord(encR(7'h00, 2, 2, 3'd1, 7));//sll 7 by 7
	addWord(encS(32'h100, 7, 3'd2));
	addWord(encR(7'h00, 2, 1, 3'd7, 8));
	addWord(encS(32'h104, 8, 3'd2));
	addWord(encR(7'h00, 2, 1, 3'd6, 9));
	addWord(encS(32'h108, 9, 3'd2));
	addWord(ECALL);
	addStore(32'h100, 4'hf, 32'h00000380);
	addStore(32'h104, 4'hf, 32'h00000003);
	addStore(32'h108, 4'hf, 32'hffffffff);
	endRow(CoreTypes::STOP, 0);

	//Loads from LOAD_WORD
	addWord(encI(32'h100, 0, 3'd0, 1, 7'h03));//lb
	addWord(encI(32'h103, 0, 3'd4, 2, 7'h03));//lbu
	addWord(encI(32'h102, 0, 3'd1, 3, 7'h03));//lh
	addWord(encI(32'h100, 0, 3'd5, 4, 7'h03));//lhu
	for (int i = 1; i <= 4; i++)
		addWord(encS(32'h13c + 4 * i, 5'(i), 3'd2));
	addWord(ECALL);
	addStore(32'h140, 4'hf, 32'hffffff91);
	addStore(32'h144, 4'hf, 32'h00000082);
	addStore(32'h148, 4'hf, 32'hffff82f1);
	addStore(32'h14c, 4'hf, 32'h00007e91);
	endRow(CoreTypes::STOP, 4);

	//Sub-word stores of a1b2c3d4
	addWord({20'ha1b2c, 5'd1, 7'h37});
	addWord(encI(32'h3d4, 1, 3'd0, 1, 7'h13));
	for (int i = 0; i < 4; i++)
		addWord(encS(32'h100 + i, 1, 3'd0));
	addWord(encS(32'h104, 1, 3'd1));
	addWord(encS(32'h106, 1, 3'd1));
	addWord(ECALL);
	for (int i = 0; i < 4; i++)
		addStore(32'h100, 4'b0001 << i, 32'hd4d4d4d4);
	addStore(32'h104, 4'b0011, 32'hc3d4c3d4);
	addStore(32'h104, 4'b1100, 32'hc3d4c3d4);
	endRow(CoreTypes::STOP, 0);

	//Control flow with skipped stores at pc 8, 24 and 32
	addWord(encI(1, 0, 3'd0, 1, 7'h13));
	addWord(encB(8, 1, 1, 3'd0));//Taken beq
	addWord(encS(32'h100, 1, 3'd2));
	addWord(encB(8, 0, 0, 3'd1));//Untaken bne
	addWord(encS(32'h104, 1, 3'd2));
	addWord(encJ(8, 2));//jal at pc 20
	addWord(encS(32'h108, 1, 3'd2));
	addWord(encI(12, 2, 3'd0, 4, 7'h67));//jalr at pc 28 to 36
	addWord(encS(32'h10c, 1, 3'd2));
	addWord(encS(32'h110, 2, 3'd2));
	addWord(encS(32'h114, 4, 3'd2));
	addWord(ECALL);
	addStore(32'h104, 4'hf, 32'h00000001);
	addStore(32'h110, 4'hf, 32'h00000018);
	addStore(32'h114, 4'hf, 32'h00000020);
	endRow(CoreTypes::STOP, 0);

	//Halts that each precede a store which must not happen
	addWord(ECALL);
	addWord(encS(32'h100, 0, 3'd2));
	endRow(CoreTypes::STOP, 0);

	addWord(encI(1, 0, 3'd0, 1, 7'h13));
	addWord(32'h00000000);
	addWord(encS(32'h100, 1, 3'd2));
	endRow(CoreTypes::CONTROL_ERROR, 0);

	addWord(encB(8, 0, 0, 3'd2));
	addWord(encS(32'h100, 0, 3'd2));
	endRow(CoreTypes::BAD_FUNCT3, 0);

	addWord(encI(32'h102, 0, 3'd2, 1, 7'h03));//lw at offset 2
	addWord(encS(32'h100, 1, 3'd2));
	endRow(CoreTypes::MISALIGNED, 0);

	for (int r = 0; r < ROWS; r++)
	begin
		reset = 1'b1;
		for (int i = 0; i < 128; i++)
			memory[i] = {16'(i * 4) ^ 16'hbeef, ~16'(i * 4)};
		for (int i = 0; i < codeLengths[r]; i++)
			memory[i] = programs[r][i];
		memory[64] = LOAD_WORD;
		expectedStores.delete();
		for (int i = 0; i < storeCounts[r]; i++)
			expectedStores.push_back(stores[r][i]);
		loadReads = 0;
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		do
		begin
			@(posedge clock);
			#1;
		end
		while (!halted);
		repeat (4) @(posedge clock);//Any late store would show up here
		#1;
		if (expectedStores.size() != 0)
			stopOnError($sformatf("Row %0d halted with %0d stores missing",
				r, expectedStores.size()));
		checkHalt(haltCause, causes[r]);
		checkLoadCount(loadReads, loadCounts[r]);
	end

	$display("ALL TESTS PASSED");
	$finish;
end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/CoreTypes.sv
hdl/ControlLogic.sv
hdl/RegisterFile.sv
hdl/ALU.sv
hdl/ImmediateFormer.sv
hdl/ProgramCounter.sv
hdl/MemoryController.sv
hdl/Core.sv
test/CoreChk.sv
test/CoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Core testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module CoreTb -o CoreSim &&
./obj_dir/CoreSim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
